// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_zx_input
FILELIST  = files.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/tb_zx_input.sv
`timescale 1ns/1ps

module tb_zx_input;

	typedef logic [7:0] byte_list_t [$];

	logic        fclk;
	logic        rst_n;
	logic        spics_n;
	logic        spick;
	logic        spido;
	logic [15:0] a;
	logic        iorq_n;
	logic        rd_n;
	logic [7:0]  d_out;
	logic        d_oe;

	int    errors = 0;
	int    tests_run = 0;
	int    tests_bad = 0;
	int    err_at_start = 0;
	int    cycle_cnt = 0;
	string cur_test;

	// model of what the z80 should see
	logic [7:0] live_cols [5];
	logic [7:0] mus_x_exp;
	logic [7:0] mus_y_exp;
	logic [7:0] mus_btn_exp;

	zx_input u_dut (
		.fclk    (fclk),
		.rst_n   (rst_n),
		.spics_n (spics_n),
		.spick   (spick),
		.spido   (spido),
		.a       (a),
		.iorq_n  (iorq_n),
		.rd_n    (rd_n),
		.d_out   (d_out),
		.d_oe    (d_oe)
	);

	initial
	begin
		fclk = 1'b0;
		forever #5 fclk = ~fclk;
	end

	// all frames and reads need about 6000 cycles
	always @(posedge fclk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= 20000)
		begin
			$display("timeout: run still going after %0d cycles", cycle_cnt);
			$display("test failed");
			$finish;
		end
	end

	task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
		begin
			errors++;
			$display("FAILED %s: %s expected %02h actual %02h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_oe(input string what, input logic exp, input logic act);
		if (act !== exp)
		begin
			errors++;
			$display("FAILED %s: %s d_oe expected %b actual %b", cur_test, what, exp, act);
		end
	endtask

	task automatic check_cmd(input string what, input zx_input_pkg::spi_cmd_e exp,
		input zx_input_pkg::spi_cmd_e act);
		if (act !== exp)
		begin
			errors++;
			$display("FAILED %s: %s expected %s (%02h) actual %s (%02h)", cur_test, what,
				exp.name(), exp, act.name(), act);
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		err_at_start = errors;
		tests_run++;
	endtask

	task automatic finish_test();
		if (errors == err_at_start)
			$display("%s: ok", cur_test);
		else
		begin
			tests_bad++;
			$display("%s: %0d mismatches", cur_test, errors - err_at_start);
		end
	endtask

	// mode 0 msb first with 8 fclk per half period
	task automatic spi_frame(input logic [7:0] cmd, input byte_list_t bytes);
		byte_list_t frame;
		frame = bytes;
		frame.push_front(cmd);
		@(posedge fclk);
		spics_n <= 1'b0;
		repeat (8) @(posedge fclk);
		foreach (frame[n])
		begin
			for (int b = 7; b >= 0; b--)
			begin
				spido <= frame[n][b];
				spick <= 1'b0;
				repeat (8) @(posedge fclk);
				spick <= 1'b1;
				repeat (8) @(posedge fclk);
			end
		end
		spick <= 1'b0;
		repeat (8) @(posedge fclk);
		spics_n <= 1'b1;
		// wait out frame_end and the live state update
		repeat (8) @(posedge fclk);
	endtask

	task automatic z80_in(input logic [15:0] addr, input logic iorq, input logic rd,
		output logic [7:0] data, output logic oe);
		@(posedge fclk);
		a      <= addr;
		iorq_n <= iorq;
		rd_n   <= rd;
		repeat (2) @(posedge fclk);
		@(negedge fclk);
		data = d_out;
		oe   = d_oe;
		@(posedge fclk);
		iorq_n <= 1'b1;
		rd_n   <= 1'b1;
	endtask

	task automatic read_port(input logic [15:0] addr, input logic [7:0] exp);
		logic [7:0] data;
		logic       oe;
		z80_in(addr, 1'b0, 1'b0, data, oe);
		check_oe($sformatf("read %04h", addr), 1'b1, oe);
		check_byte($sformatf("read %04h", addr), exp, data);
	endtask

	task automatic read_none(input logic [15:0] addr, input logic iorq, input logic rd);
		logic [7:0] data;
		logic       oe;
		z80_in(addr, iorq, rd, data, oe);
		check_oe($sformatf("cycle %04h iorq_n=%b rd_n=%b", addr, iorq, rd), 1'b0, oe);
		check_byte($sformatf("cycle %04h iorq_n=%b rd_n=%b", addr, iorq, rd), 8'hFF, data);
	endtask

	// zero address bits select half-rows
	// pressed keys pull their column low
	function automatic logic [7:0] kbd_expect(input logic [7:0] hi);
		logic [7:0] r;
		r = 8'hFF;
		for (int col = 0; col < 5; col++)
			for (int row = 0; row < 8; row++)
				if (!hi[row] && !live_cols[col][row])
					r[col] = 1'b0;
		return r;
	endfunction

	task automatic check_matrix();
		logic [7:0] hi;
		for (int j = 0; j < 8; j++)
			read_port({~(8'h01 << j), 8'hFE}, kbd_expect(~(8'h01 << j)));
		read_port(16'h00FE, kbd_expect(8'h00));
		read_port(16'hFFFE, kbd_expect(8'hFF));
		for (int k = 0; k < 4; k++)
		begin
			hi = 8'($urandom());
			read_port({hi, 8'hFE}, kbd_expect(hi));
		end
	endtask

	task automatic check_mouse();
		read_port(zx_input_pkg::PORT_MUS_X, mus_x_exp);
		read_port(zx_input_pkg::PORT_MUS_Y, mus_y_exp);
		read_port(zx_input_pkg::PORT_MUS_BTN, mus_btn_exp);
	endtask

	task automatic send_kbd(input int count);
		byte_list_t bytes;
		for (int i = 0; i < count; i++)
			bytes.push_back(8'($urandom()));
		spi_frame(zx_input_pkg::CMD_KBD, bytes);
		check_cmd("frame cmd", zx_input_pkg::CMD_KBD, u_dut.link_bus.cmd);
		if (count >= 5)
			for (int i = 0; i < 5; i++)
				live_cols[i] = bytes[i];
	endtask

	// trailing bytes differ from the first one
	task automatic send_mouse(input zx_input_pkg::spi_cmd_e cmd, output logic [7:0] first);
		byte_list_t bytes;
		first = 8'($urandom());
		bytes.push_back(first);
		bytes.push_back(~first);
		bytes.push_back(first + 8'h5A);
		spi_frame(cmd, bytes);
		check_cmd("frame cmd", cmd, u_dut.link_bus.cmd);
	endtask

	task automatic test_reset_state();
		logic [7:0] data;
		logic       oe;
		start_test("reset_state");
		read_port({8'($urandom()), 8'hFE}, 8'hFF);
		read_port(16'h0000, 8'hFF);
		check_mouse();
		z80_in(16'h00FE, 1'b1, 1'b1, data, oe);
		check_oe("idle bus", 1'b0, oe);
		check_byte("idle bus", 8'hFF, data);
		finish_test();
	endtask

	task automatic test_kbd_matrix();
		start_test("kbd_matrix");
		send_kbd(5);
		check_matrix();
		finish_test();
	endtask

	task automatic test_torn_frame();
		start_test("torn_frame");
		send_kbd(3);
		check_matrix();
		send_kbd(6);
		check_matrix();
		finish_test();
	endtask

	task automatic test_mouse();
		byte_list_t junk;
		start_test("mouse_regs");
		send_mouse(zx_input_pkg::CMD_MUS_X, mus_x_exp);
		send_mouse(zx_input_pkg::CMD_MUS_Y, mus_y_exp);
		send_mouse(zx_input_pkg::CMD_MUS_BTN, mus_btn_exp);
		check_mouse();
		// long enough that a keyboard decode would commit
		for (int i = 0; i < 6; i++)
			junk.push_back(8'($urandom()));
		spi_frame(8'h55, junk);
		check_cmd("unknown cmd", zx_input_pkg::CMD_NOP, u_dut.link_bus.cmd);
		check_mouse();
		check_matrix();
		finish_test();
	endtask

	task automatic test_port_decode();
		logic [15:0] addr;
		start_test("port_decode");
		read_none(16'h00FF, 1'b0, 1'b0);
		read_none(16'hFBDD, 1'b0, 1'b0);
		read_none(16'hFFFF, 1'b0, 1'b0);
		for (int k = 0; k < 4; k++)
		begin
			addr = 16'($urandom()) | 16'h0001;
			if (addr inside {zx_input_pkg::PORT_MUS_X, zx_input_pkg::PORT_MUS_Y,
				zx_input_pkg::PORT_MUS_BTN})
				addr = 16'h0001;
			read_none(addr, 1'b0, 1'b0);
		end
		// write cycles and memory reads
		read_none(16'h00FE, 1'b0, 1'b1);
		read_none(zx_input_pkg::PORT_MUS_X, 1'b0, 1'b1);
		read_none(zx_input_pkg::PORT_MUS_BTN, 1'b1, 1'b0);
		finish_test();
	endtask

	initial
	begin
		void'($urandom(88588));
		rst_n   <= 1'b0;
		spics_n <= 1'b1;
		spick   <= 1'b0;
		spido   <= 1'b0;
		a       <= 16'h0000;
		iorq_n  <= 1'b1;
		rd_n    <= 1'b1;
		for (int i = 0; i < 5; i++)
			live_cols[i] = 8'hFF;
		mus_x_exp   = 8'h00;
		mus_y_exp   = 8'h00;
		mus_btn_exp = 8'hFF;
		repeat (3) @(posedge fclk);
		rst_n <= 1'b1;
		@(posedge fclk);

		test_reset_state();
		test_kbd_matrix();
		test_torn_frame();
		test_mouse();
		test_port_decode();

		$display("tests run %0d, tests with mismatches %0d, mismatches %0d",
			tests_run, tests_bad, errors);
		if (errors == 0 && tests_bad == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: bench/zx_input_properties.sv
`timescale 1ns/1ps

module zx_input_properties (
	input logic                    fclk,
	input logic                    rst_n,
	input logic [15:0]             a,
	input logic                    iorq_n,
	input logic                    rd_n,
	input logic [7:0]              d_out,
	input logic                    d_oe,
	input logic                    byte_stb,
	input logic                    frame_end,
	input zx_input_pkg::rx_state_e rx_state
);

	// bus enable only one cycle after a z80 read
	a_oe_after_read: assert property (@(posedge fclk) disable iff (!rst_n)
		d_oe |-> $past(!iorq_n && !rd_n))
		else $error("d_oe high without a read cycle the cycle before");

	// ula port, unused top bits and tape input read 1
	a_fe_top_bits: assert property (@(posedge fclk) disable iff (!rst_n)
		(d_oe && !$past(a[0])) |-> (d_out[7:5] == 3'b111))
		else $error("port FE read returned bits 7 to 5 not all set");

	a_stb_vs_end: assert property (@(posedge fclk) disable iff (!rst_n)
		!(byte_stb && frame_end))
		else $error("byte_stb and frame_end high in the same cycle");

	a_stb_state: assert property (@(posedge fclk) disable iff (!rst_n)
		byte_stb |-> (rx_state == zx_input_pkg::RX_DATA))
		else $error("byte_stb high outside RX_DATA");

endmodule

bind zx_input zx_input_properties u_props (
	.fclk      (fclk),
	.rst_n     (rst_n),
	.a         (a),
	.iorq_n    (iorq_n),
	.rd_n      (rd_n),
	.d_out     (d_out),
	.d_oe      (d_oe),
	.byte_stb  (link_bus.byte_stb),
	.frame_end (link_bus.frame_end),
	.rx_state  (u_rx.rx_state)
);

// File: design/input_state_if.sv
`timescale 1ns/1ps

interface input_state_if;

	// column i in bits 8*i+7 .. 8*i, one bit per half-row
	logic [39:0] kbd;
	logic [7:0]  mus_x;
	logic [7:0]  mus_y;
	logic [7:0]  mus_btn;

	modport src (
		output kbd, mus_x, mus_y, mus_btn
	);

	modport snk (
		input kbd, mus_x, mus_y, mus_btn
	);

endinterface

// File: design/kbd_mus_store.sv
`timescale 1ns/1ps

module kbd_mus_store (
	input  logic        fclk,
	input  logic        rst_n,
	spi_link_if.rx      link,
	input_state_if.src  state
);

	logic [39:0] shadow;
	logic        mus_taken;
	logic        kbd_byte;
	logic        kbd_commit;

	assign kbd_byte = link.byte_stb && (link.cmd == zx_input_pkg::CMD_KBD)
		&& (link.idx < zx_input_pkg::KBD_BYTES);

	// idx still holds the last byte of this frame
	assign kbd_commit = link.frame_end && (link.cmd == zx_input_pkg::CMD_KBD)
		&& (link.idx >= zx_input_pkg::KBD_BYTES - 3'd1);

	always_ff @(posedge fclk)
	begin
		if (kbd_byte)
			shadow[{link.idx, 3'b000} +: 8] <= link.data;
	end

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			state.kbd     <= zx_input_pkg::KBD_RESET;
			state.mus_x   <= zx_input_pkg::MUS_XY_RESET;
			state.mus_y   <= zx_input_pkg::MUS_XY_RESET;
			state.mus_btn <= zx_input_pkg::MUS_BTN_RESET;
			mus_taken     <= 1'b0;
		end
		else
		begin
			if (kbd_commit)
				state.kbd <= shadow;

			if (link.frame_end)
				mus_taken <= 1'b0;
			else if (link.byte_stb && !mus_taken)
			begin
				case (link.cmd)
					zx_input_pkg::CMD_MUS_X:   state.mus_x   <= link.data;
					zx_input_pkg::CMD_MUS_Y:   state.mus_y   <= link.data;
					zx_input_pkg::CMD_MUS_BTN: state.mus_btn <= link.data;
					default: ;
				endcase
				// only the first mouse byte of a frame counts
				if (link.cmd inside {zx_input_pkg::CMD_MUS_X, zx_input_pkg::CMD_MUS_Y,
					zx_input_pkg::CMD_MUS_BTN})
					mus_taken <= 1'b1;
			end
		end
	end

endmodule

// File: design/spi_cmd_rx.sv
`timescale 1ns/1ps

module spi_cmd_rx (
	input  logic   fclk,
	input  logic   rst_n,
	input  logic   spics_n,
	input  logic   spick,
	input  logic   spido,
	spi_link_if.tx link
);

	// stages 0 and 1 synchronize, stage 2 is the previous value for edges
	logic [2:0] ck_sync;
	logic [2:0] cs_sync;
	logic [1:0] do_sync;

	logic ck_rise;
	logic cs_fall;
	logic cs_rise;
	logic bit_take;
	logic byte_done;

	zx_input_pkg::rx_state_e rx_state;
	logic [2:0] bit_cnt;
	logic [2:0] nbytes;
	logic [6:0] shreg;
	logic [7:0] rx_byte;

	function automatic zx_input_pkg::spi_cmd_e to_cmd(input logic [7:0] b);
		case (b)
			zx_input_pkg::CMD_KBD:     to_cmd = zx_input_pkg::CMD_KBD;
			zx_input_pkg::CMD_MUS_X:   to_cmd = zx_input_pkg::CMD_MUS_X;
			zx_input_pkg::CMD_MUS_Y:   to_cmd = zx_input_pkg::CMD_MUS_Y;
			zx_input_pkg::CMD_MUS_BTN: to_cmd = zx_input_pkg::CMD_MUS_BTN;
			default:                   to_cmd = zx_input_pkg::CMD_NOP;
		endcase
	endfunction

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			ck_sync <= 3'b000;
			cs_sync <= 3'b111;
		end
		else
		begin
			ck_sync <= {ck_sync[1:0], spick};
			cs_sync <= {cs_sync[1:0], spics_n};
		end
	end

	always_ff @(posedge fclk)
	begin
		do_sync <= {do_sync[0], spido};
	end

	assign ck_rise = ck_sync[1] & ~ck_sync[2];
	assign cs_fall = cs_sync[2] & ~cs_sync[1];
	assign cs_rise = ~cs_sync[2] & cs_sync[1];

	// chip select edges win over a clock edge in the same cycle
	assign bit_take  = ck_rise && (rx_state != zx_input_pkg::RX_IDLE) && !cs_rise && !cs_fall;
	assign byte_done = bit_take && (bit_cnt == 3'd7);
	assign rx_byte   = {shreg, do_sync[1]};

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			rx_state       <= zx_input_pkg::RX_IDLE;
			bit_cnt        <= 3'd0;
			nbytes         <= 3'd0;
			link.byte_stb  <= 1'b0;
			link.frame_end <= 1'b0;
		end
		else
		begin
			link.byte_stb  <= 1'b0;
			link.frame_end <= 1'b0;
			if (cs_rise)
			begin
				rx_state       <= zx_input_pkg::RX_IDLE;
				link.frame_end <= (nbytes != 3'd0);
			end
			else if (cs_fall)
			begin
				rx_state <= zx_input_pkg::RX_CMD;
				bit_cnt  <= 3'd0;
				nbytes   <= 3'd0;
			end
			else if (bit_take)
			begin
				bit_cnt <= bit_cnt + 3'd1;
				if (byte_done && rx_state == zx_input_pkg::RX_CMD)
					rx_state <= zx_input_pkg::RX_DATA;
				if (byte_done && rx_state == zx_input_pkg::RX_DATA)
				begin
					link.byte_stb <= 1'b1;
					link.idx      <= nbytes;
					// saturate, the store ignores anything past column 4
					if (nbytes != 3'd7)
						nbytes <= nbytes + 3'd1;
				end
			end
		end
	end

	always_ff @(posedge fclk)
	begin
		if (bit_take)
			shreg <= rx_byte[6:0];
		if (byte_done && rx_state == zx_input_pkg::RX_CMD)
			link.cmd <= to_cmd(rx_byte);
		if (byte_done && rx_state == zx_input_pkg::RX_DATA)
			link.data <= rx_byte;
	end

endmodule

// File: design/spi_link_if.sv
`timescale 1ns/1ps

interface spi_link_if;

	logic [7:0]            data;
	zx_input_pkg::spi_cmd_e cmd;
	logic [2:0]            idx;
	logic                  byte_stb;
	logic                  frame_end;

	modport tx (
		output data, cmd, idx, byte_stb, frame_end
	);

	modport rx (
		input data, cmd, idx, byte_stb, frame_end
	);

endinterface

// File: design/zport_reader.sv
`timescale 1ns/1ps

module zport_reader (
	input  logic        fclk,
	input  logic        rst_n,
	input  logic [15:0] a,
	input  logic        iorq_n,
	input  logic        rd_n,
	input_state_if.snk  state,
	output logic [7:0]  dout,
	output logic        dataout
);

	logic       rd_cyc;
	logic       hit_kbd;
	logic       hit_x;
	logic       hit_y;
	logic       hit_btn;
	logic [4:0] keys;
	logic [7:0] dout_next;
	logic       oe_next;

	assign rd_cyc  = ~iorq_n & ~rd_n;
	assign hit_kbd = (a[0] == zx_input_pkg::PORT_KBD_LO[0]);
	assign hit_x   = (a == zx_input_pkg::PORT_MUS_X);
	assign hit_y   = (a == zx_input_pkg::PORT_MUS_Y);
	assign hit_btn = (a == zx_input_pkg::PORT_MUS_BTN);

	// unselected half-rows are forced to 1 before the and
	always_comb
	begin
		for (int i = 0; i < zx_input_pkg::KBD_BYTES; i++)
			keys[i] = &(state.kbd[8*i +: 8] | a[15:8]);
	end

	always_comb
	begin
		oe_next   = 1'b0;
		dout_next = 8'hFF;
		if (rd_cyc)
		begin
			oe_next = 1'b1;
			if (hit_kbd)
				dout_next = {3'b111, keys};
			else if (hit_x)
				dout_next = state.mus_x;
			else if (hit_y)
				dout_next = state.mus_y;
			else if (hit_btn)
				dout_next = state.mus_btn;
			else
				oe_next = 1'b0;
		end
	end

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			dout    <= 8'hFF;
			dataout <= 1'b0;
		end
		else
		begin
			dout    <= dout_next;
			dataout <= oe_next;
		end
	end

endmodule

// File: design/zx_input.sv
`timescale 1ns/1ps

module zx_input (
	input  logic        fclk,
	input  logic        rst_n,

	// board controller link
	input  logic        spics_n,
	input  logic        spick,
	input  logic        spido,

	// z80 side
	input  logic [15:0] a,
	input  logic        iorq_n,
	input  logic        rd_n,
	output logic [7:0]  d_out,
	output logic        d_oe
);

	spi_link_if    link_bus ();
	input_state_if state_bus ();

	spi_cmd_rx u_rx (
		.fclk    (fclk),
		.rst_n   (rst_n),
		.spics_n (spics_n),
		.spick   (spick),
		.spido   (spido),
		.link    (link_bus.tx)
	);

	kbd_mus_store u_store (
		.fclk  (fclk),
		.rst_n (rst_n),
		.link  (link_bus.rx),
		.state (state_bus.src)
	);

	zport_reader u_reader (
		.fclk    (fclk),
		.rst_n   (rst_n),
		.a       (a),
		.iorq_n  (iorq_n),
		.rd_n    (rd_n),
		.state   (state_bus.snk),
		.dout    (d_out),
		.dataout (d_oe)
	);

endmodule

// File: design/zx_input_pkg.sv
package zx_input_pkg;

	// first byte of a frame from the board controller
	typedef enum logic [7:0] {
		CMD_NOP     = 8'h00,
		CMD_KBD     = 8'h10,
		CMD_MUS_X   = 8'h20,
		CMD_MUS_Y   = 8'h21,
		CMD_MUS_BTN = 8'h22
	} spi_cmd_e;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_CMD,
		RX_DATA
	} rx_state_e;

	// key columns per keyboard frame
	localparam logic [2:0] KBD_BYTES = 3'd5;

	// a[0] low selects the ula port
	localparam logic [7:0] PORT_KBD_LO = 8'hFE;

	// kempston ports, full decode
	localparam logic [15:0] PORT_MUS_X   = 16'hFBDF;
	localparam logic [15:0] PORT_MUS_Y   = 16'hFFDF;
	localparam logic [15:0] PORT_MUS_BTN = 16'hFADF;

	// all keys released
	localparam logic [39:0] KBD_RESET     = {40{1'b1}};
	localparam logic [7:0]  MUS_XY_RESET  = 8'h00;
	localparam logic [7:0]  MUS_BTN_RESET = 8'hFF;

endpackage

// File: files.f
design/zx_input_pkg.sv
design/spi_link_if.sv
design/input_state_if.sv
design/spi_cmd_rx.sv
design/kbd_mus_store.sv
design/zport_reader.sv
design/zx_input.sv
bench/zx_input_properties.sv
bench/tb_zx_input.sv
